// File: src/clint_defs.svh
`ifndef CLINT_DEFS_SVH
`define CLINT_DEFS_SVH

// Cluster size and datapath widths
`define CLINT_NUM_HARTS   4
`define CLINT_DATA_W      32
`define CLINT_ADDR_W      16
`define CLINT_TIME_W      64
`define CLINT_HART_IDX_W  8
`define CLINT_SYNC_STAGES 2

// ------------------------------------------------------------------------
// Register map, byte offsets
// ------------------------------------------------------------------------
// MSIP stride is 4 per hart, compare stride is 8 per hart (lo at +0, hi at +4)
`define CLINT_MSIP_BASE   'h0000
`define CLINT_CMP_BASE    'h4000
`define CLINT_MTIME_LO    'hBFF8
`define CLINT_MTIME_HI    'hBFFC
`define CLINT_BCAST       'hC000
`define CLINT_CLR         'hC004

`endif

// File: src/clint_bus_pkg.sv
`include "clint_defs.svh"

package clint_bus_pkg;

    typedef logic [`CLINT_ADDR_W-1:0] addr_t;
    typedef logic [`CLINT_DATA_W-1:0] data_t;

    typedef enum logic [2:0] {
        REG_MSIP,
        REG_CMP_LO,
        REG_CMP_HI,
        REG_MTIME_LO,
        REG_MTIME_HI,
        REG_BCAST,
        REG_CLR,
        REG_NONE
    } reg_sel_e;

    // Per-hart ranges stop at the hart count, misaligned words never hit
    function automatic reg_sel_e decode_sel(addr_t addr);
        int unsigned a;
        reg_sel_e    sel;
        a   = 32'(addr);
        sel = REG_NONE;
        if (addr[1:0] == 2'b00) begin
            if (a >= `CLINT_MSIP_BASE && a < `CLINT_MSIP_BASE + 4 * `CLINT_NUM_HARTS) begin
                sel = REG_MSIP;
            end else if (a >= `CLINT_CMP_BASE && a < `CLINT_CMP_BASE + 8 * `CLINT_NUM_HARTS) begin
                sel = addr[2] ? REG_CMP_HI : REG_CMP_LO;
            end else if (a == `CLINT_MTIME_LO) begin
                sel = REG_MTIME_LO;
            end else if (a == `CLINT_MTIME_HI) begin
                sel = REG_MTIME_HI;
            end else if (a == `CLINT_BCAST) begin
                sel = REG_BCAST;
            end else if (a == `CLINT_CLR) begin
                sel = REG_CLR;
            end
        end
        return sel;
    endfunction

    // Only meaningful when decode_sel names a per-hart register
    function automatic logic [`CLINT_HART_IDX_W-1:0] decode_hart(addr_t addr);
        int unsigned off;
        if (32'(addr) >= `CLINT_CMP_BASE) begin
            off = (32'(addr) - `CLINT_CMP_BASE) >> 3;
        end else begin
            off = (32'(addr) - `CLINT_MSIP_BASE) >> 2;
        end
        return off[`CLINT_HART_IDX_W-1:0];
    endfunction

endpackage

// File: src/clint_time_pkg.sv
`include "clint_defs.svh"

package clint_time_pkg;

    typedef logic [`CLINT_TIME_W-1:0]     mtime_t;
    typedef logic [`CLINT_HART_IDX_W-1:0] hart_idx_t;

    // One bit or one entry per hart
    typedef logic [`CLINT_NUM_HARTS-1:0]  hart_vec_t;
    typedef mtime_t [`CLINT_NUM_HARTS-1:0] cmp_array_t;

endpackage

// File: src/clint_rtc_tick.sv
`timescale 1ns/1ns
`include "clint_defs.svh"

module clint_rtc_tick (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic rtc_i,
    output logic tick_o
);

    logic [`CLINT_SYNC_STAGES-1:0] sync_q;
    logic                          level_q;
    logic                          tick_q;

    // Two flops against metastability, then edge detect on the clean level
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sync_q  <= '0;
            level_q <= 1'b0;
            tick_q  <= 1'b0;
        end else begin
            sync_q  <= {sync_q[`CLINT_SYNC_STAGES-2:0], rtc_i};
            level_q <= sync_q[`CLINT_SYNC_STAGES-1];
            tick_q  <= sync_q[`CLINT_SYNC_STAGES-1] & ~level_q;
        end
    end

    assign tick_o = tick_q;

    // RTC is far slower than the core clock
    a_tick_single : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        tick_o |-> !$past(tick_o) && !$past(tick_o, 2));

endmodule

// File: src/clint_reg_front.sv
`timescale 1ns/1ns
`include "clint_defs.svh"

module clint_reg_front (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      req_i,
    input  logic                      we_i,
    input  clint_bus_pkg::addr_t      addr_i,
    input  clint_bus_pkg::data_t      wdata_i,
    input  logic                      tick_i,
    output clint_time_pkg::mtime_t    mtime_o,
    output clint_time_pkg::hart_vec_t cmp_lo_we_o,
    output clint_time_pkg::hart_vec_t cmp_hi_we_o,
    output clint_time_pkg::hart_vec_t msip_we_o,
    output clint_time_pkg::hart_vec_t msip_set_o,
    output clint_time_pkg::hart_vec_t msip_clr_o,
    output clint_bus_pkg::data_t      wdata_o
);

    clint_bus_pkg::reg_sel_e   sel;
    clint_time_pkg::hart_idx_t hart;
    clint_time_pkg::mtime_t    mtime_q;
    logic                      wr;

    assign wr   = req_i & we_i;
    assign sel  = clint_bus_pkg::decode_sel(addr_i);
    assign hart = clint_bus_pkg::decode_hart(addr_i);

    // ------------------------------------------------------------------------
    // Real-time counter
    // ------------------------------------------------------------------------
    // Bus write beats the tick
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtime_q <= '0;
        end else if (wr && sel == clint_bus_pkg::REG_MTIME_LO) begin
            mtime_q[`CLINT_DATA_W-1:0] <= wdata_i;
        end else if (wr && sel == clint_bus_pkg::REG_MTIME_HI) begin
            mtime_q[`CLINT_TIME_W-1:`CLINT_DATA_W] <= wdata_i;
        end else if (tick_i) begin
            mtime_q <= mtime_q + clint_time_pkg::mtime_t'(1);
        end
    end

    assign mtime_o = mtime_q;
    assign wdata_o = wdata_i;

    // ------------------------------------------------------------------------
    // Per-hart strobes
    // ------------------------------------------------------------------------
    always_comb begin
        logic hit;
        cmp_lo_we_o = '0;
        cmp_hi_we_o = '0;
        msip_we_o   = '0;
        msip_set_o  = '0;
        msip_clr_o  = '0;
        for (int i = 0; i < `CLINT_NUM_HARTS; i++) begin
            hit            = wr && (hart == clint_time_pkg::hart_idx_t'(i));
            cmp_lo_we_o[i] = hit && (sel == clint_bus_pkg::REG_CMP_LO);
            cmp_hi_we_o[i] = hit && (sel == clint_bus_pkg::REG_CMP_HI);
            msip_we_o[i]   = hit && (sel == clint_bus_pkg::REG_MSIP);
        end
        // Hart 0 is out of reach of broadcast and clear
        for (int i = 1; i < `CLINT_NUM_HARTS; i++) begin
            msip_set_o[i] = wr && (sel == clint_bus_pkg::REG_BCAST) &&
                            (wdata_i >= clint_bus_pkg::data_t'(i - 1));
            msip_clr_o[i] = wr && (sel == clint_bus_pkg::REG_CLR) &&
                            (wdata_i == clint_bus_pkg::data_t'(i));
        end
    end

    a_set_clr_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !((|msip_set_o) && (|msip_clr_o)));

endmodule

// File: src/clint_hart_slot.sv
`timescale 1ns/1ns
`include "clint_defs.svh"

module clint_hart_slot (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  clint_time_pkg::mtime_t mtime_i,
    input  logic                   cmp_lo_we_i,
    input  logic                   cmp_hi_we_i,
    input  logic                   msip_we_i,
    input  logic                   msip_set_i,
    input  logic                   msip_clr_i,
    input  clint_bus_pkg::data_t   wdata_i,
    output clint_time_pkg::mtime_t mtimecmp_o,
    output logic                   timer_irq_o,
    output logic                   ipi_o
);

    clint_time_pkg::mtime_t cmp_q;
    logic                   msip_q;

    // All ones keeps the timer quiet until software programs it
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cmp_q <= '1;
        end else begin
            if (cmp_lo_we_i) begin
                cmp_q[`CLINT_DATA_W-1:0] <= wdata_i;
            end
            if (cmp_hi_we_i) begin
                cmp_q[`CLINT_TIME_W-1:`CLINT_DATA_W] <= wdata_i;
            end
        end
    end

    // Set over clear over direct write
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            msip_q <= 1'b0;
        end else if (msip_set_i) begin
            msip_q <= 1'b1;
        end else if (msip_clr_i) begin
            msip_q <= 1'b0;
        end else if (msip_we_i) begin
            msip_q <= wdata_i[0];
        end
    end

    assign mtimecmp_o  = cmp_q;
    assign ipi_o       = msip_q;
    assign timer_irq_o = (mtime_i >= cmp_q);

    // IRQ only moves when the compare was written or mtime moved
    a_irq_cause : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $changed(timer_irq_o) |-> $past(cmp_lo_we_i || cmp_hi_we_i) || $changed(mtime_i));

endmodule

// File: src/clint_read_mux.sv
`timescale 1ns/1ns
`include "clint_defs.svh"

module clint_read_mux (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       req_i,
    input  logic                       we_i,
    input  clint_bus_pkg::addr_t       addr_i,
    input  clint_time_pkg::mtime_t     mtime_i,
    input  clint_time_pkg::cmp_array_t mtimecmp_i,
    input  clint_time_pkg::hart_vec_t  msip_i,
    output logic                       rsp_valid_o,
    output clint_bus_pkg::data_t       rdata_o
);

    clint_bus_pkg::reg_sel_e   sel;
    clint_time_pkg::hart_idx_t hart;
    clint_bus_pkg::data_t      rdata_d;
    logic                      rd;

    assign rd   = req_i & ~we_i;
    assign sel  = clint_bus_pkg::decode_sel(addr_i);
    assign hart = clint_bus_pkg::decode_hart(addr_i);

    always_comb begin
        logic                   msip_bit;
        clint_time_pkg::mtime_t cmp_word;
        msip_bit = 1'b0;
        cmp_word = '0;
        for (int i = 0; i < `CLINT_NUM_HARTS; i++) begin
            if (hart == clint_time_pkg::hart_idx_t'(i)) begin
                msip_bit = msip_i[i];
                cmp_word = mtimecmp_i[i];
            end
        end
        // Broadcast, clear and holes read as zero
        case (sel)
            clint_bus_pkg::REG_MSIP:     rdata_d = clint_bus_pkg::data_t'(msip_bit);
            clint_bus_pkg::REG_CMP_LO:   rdata_d = cmp_word[`CLINT_DATA_W-1:0];
            clint_bus_pkg::REG_CMP_HI:   rdata_d = cmp_word[`CLINT_TIME_W-1:`CLINT_DATA_W];
            clint_bus_pkg::REG_MTIME_LO: rdata_d = mtime_i[`CLINT_DATA_W-1:0];
            clint_bus_pkg::REG_MTIME_HI: rdata_d = mtime_i[`CLINT_TIME_W-1:`CLINT_DATA_W];
            default:                     rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= rd;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd) begin
            rdata_o <= rdata_d;
        end
    end

    a_rsp_follows_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o |-> $past(req_i && !we_i));

endmodule

// File: src/clint.sv
`timescale 1ns/1ns
`include "clint_defs.svh"

module clint (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      req_i,
    input  logic                      we_i,
    input  clint_bus_pkg::addr_t      addr_i,
    input  clint_bus_pkg::data_t      wdata_i,
    input  logic                      rtc_i,
    output logic                      rsp_valid_o,
    output clint_bus_pkg::data_t      rdata_o,
    output clint_time_pkg::hart_vec_t timer_irq_o,
    output clint_time_pkg::hart_vec_t ipi_o
);

    logic                       tick;
    clint_time_pkg::mtime_t     mtime;
    clint_time_pkg::cmp_array_t mtimecmp;
    clint_time_pkg::hart_vec_t  cmp_lo_we;
    clint_time_pkg::hart_vec_t  cmp_hi_we;
    clint_time_pkg::hart_vec_t  msip_we;
    clint_time_pkg::hart_vec_t  msip_set;
    clint_time_pkg::hart_vec_t  msip_clr;
    clint_bus_pkg::data_t       wdata;

    clint_rtc_tick u_rtc_tick (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rtc_i   (rtc_i),
        .tick_o  (tick)
    );

    clint_reg_front u_reg_front (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .tick_i      (tick),
        .mtime_o     (mtime),
        .cmp_lo_we_o (cmp_lo_we),
        .cmp_hi_we_o (cmp_hi_we),
        .msip_we_o   (msip_we),
        .msip_set_o  (msip_set),
        .msip_clr_o  (msip_clr),
        .wdata_o     (wdata)
    );

    // ------------------------------------------------------------------------
    // One slot per hart
    // ------------------------------------------------------------------------
    for (genvar h = 0; h < `CLINT_NUM_HARTS; h++) begin : g_hart
        clint_hart_slot u_slot (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .mtime_i     (mtime),
            .cmp_lo_we_i (cmp_lo_we[h]),
            .cmp_hi_we_i (cmp_hi_we[h]),
            .msip_we_i   (msip_we[h]),
            .msip_set_i  (msip_set[h]),
            .msip_clr_i  (msip_clr[h]),
            .wdata_i     (wdata),
            .mtimecmp_o  (mtimecmp[h]),
            .timer_irq_o (timer_irq_o[h]),
            .ipi_o       (ipi_o[h])
        );
    end

    clint_read_mux u_read_mux (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .mtime_i     (mtime),
        .mtimecmp_i  (mtimecmp),
        .msip_i      (ipi_o),
        .rsp_valid_o (rsp_valid_o),
        .rdata_o     (rdata_o)
    );

endmodule

// File: verif/tb_clint.sv
`timescale 1ns/1ns
`include "clint_defs.svh"

module tb_clint;

    localparam clint_bus_pkg::addr_t MTIME_LO_A = clint_bus_pkg::addr_t'(`CLINT_MTIME_LO);
    localparam clint_bus_pkg::addr_t MTIME_HI_A = clint_bus_pkg::addr_t'(`CLINT_MTIME_HI);
    localparam clint_bus_pkg::addr_t BCAST_A    = clint_bus_pkg::addr_t'(`CLINT_BCAST);
    localparam clint_bus_pkg::addr_t CLR_A      = clint_bus_pkg::addr_t'(`CLINT_CLR);
    localparam clint_bus_pkg::addr_t HOLE_A     = 16'h8000;

    logic                      clk_i;
    logic                      rst_n_i;
    logic                      req_i;
    logic                      we_i;
    clint_bus_pkg::addr_t      addr_i;
    clint_bus_pkg::data_t      wdata_i;
    logic                      rtc_i;
    logic                      rsp_valid_o;
    clint_bus_pkg::data_t      rdata_o;
    clint_time_pkg::hart_vec_t timer_irq_o;
    clint_time_pkg::hart_vec_t ipi_o;

    // Reference copy of the register file
    clint_time_pkg::mtime_t    mtime_m;
    clint_time_pkg::mtime_t    cmp_m [`CLINT_NUM_HARTS];
    clint_time_pkg::hart_vec_t msip_m;

    logic [15:0] lfsr;
    int          errors;
    int          errors_before;
    int          passed;
    int          failed;

    clint uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    // 16-bit Galois LFSR, one step per bit
    function automatic clint_bus_pkg::data_t rand_bits(int n);
        clint_bus_pkg::data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[`CLINT_DATA_W-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic clint_bus_pkg::addr_t msip_addr(int h);
        return clint_bus_pkg::addr_t'(`CLINT_MSIP_BASE + 4 * h);
    endfunction

    function automatic clint_bus_pkg::addr_t cmp_addr(int h, int hi);
        return clint_bus_pkg::addr_t'(`CLINT_CMP_BASE + 8 * h + 4 * hi);
    endfunction

    // Timer pending while mtime >= compare
    function automatic clint_time_pkg::hart_vec_t irq_model();
        clint_time_pkg::hart_vec_t v;
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            v[h] = (mtime_m >= cmp_m[h]);
        end
        return v;
    endfunction

    task automatic bus_write(clint_bus_pkg::addr_t addr, clint_bus_pkg::data_t data);
        @(posedge clk_i);
        req_i   <= 1'b1;
        we_i    <= 1'b1;
        addr_i  <= addr;
        wdata_i <= data;
        @(posedge clk_i);
        req_i   <= 1'b0;
        we_i    <= 1'b0;
    endtask

    task automatic bus_read(clint_bus_pkg::addr_t addr, output clint_bus_pkg::data_t data);
        int wait_cycles;
        @(posedge clk_i);
        req_i  <= 1'b1;
        we_i   <= 1'b0;
        addr_i <= addr;
        @(posedge clk_i);
        req_i  <= 1'b0;
        wait_cycles = 0;
        @(negedge clk_i);
        while (!rsp_valid_o && wait_cycles < 8) begin
            @(negedge clk_i);
            wait_cycles++;
        end
        if (!rsp_valid_o) begin
            $display("Read of address %h got no response within 8 cycles", addr);
            errors++;
        end else if (wait_cycles != 0) begin
            $display("Read of address %h answered %0d cycles late", addr, wait_cycles);
            errors++;
        end
        data = rdata_o;
        @(negedge clk_i);
        check_flag(rsp_valid_o, 1'b0, "rsp_valid one cycle after response");
    endtask

    task automatic check_data(clint_bus_pkg::data_t got, clint_bus_pkg::data_t exp,
                              string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_harts(clint_time_pkg::hart_vec_t got, clint_time_pkg::hart_vec_t exp,
                               string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic expect_read(clint_bus_pkg::addr_t addr, clint_bus_pkg::data_t exp,
                               string what);
        clint_bus_pkg::data_t d;
        bus_read(addr, d);
        check_data(d, exp, what);
    endtask

    task automatic set_mtime(clint_time_pkg::mtime_t v);
        bus_write(MTIME_LO_A, v[31:0]);
        bus_write(MTIME_HI_A, v[63:32]);
        mtime_m = v;
    endtask

    task automatic set_cmp(int h, clint_time_pkg::mtime_t v);
        bus_write(cmp_addr(h, 0), v[31:0]);
        bus_write(cmp_addr(h, 1), v[63:32]);
        cmp_m[h] = v;
    endtask

    task automatic pulse_rtc();
        @(posedge clk_i);
        rtc_i <= 1'b1;
        repeat (6) @(posedge clk_i);
        rtc_i <= 1'b0;
        repeat (6) @(posedge clk_i);
    endtask

    // Poll until the counter shows the expected low word
    task automatic wait_mtime_lo(clint_bus_pkg::data_t exp);
        clint_bus_pkg::data_t d;
        int                   polls;
        polls = 0;
        bus_read(MTIME_LO_A, d);
        while (d !== exp && polls < 8) begin
            bus_read(MTIME_LO_A, d);
            polls++;
        end
        check_data(d, exp, "mtime lo after rtc edge");
    endtask

    task automatic end_test(string name);
        if (errors == errors_before) begin
            passed++;
            $display("%0t ns: test %s ok", $time, name);
        end else begin
            failed++;
            $display("%0t ns: test %s failed, %0d errors", $time, name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic reset_state();
        @(negedge clk_i);
        check_harts(timer_irq_o, '0, "timer_irq after reset");
        check_harts(ipi_o, '0, "ipi after reset");
        check_flag(rsp_valid_o, 1'b0, "rsp_valid after reset");
        expect_read(MTIME_LO_A, '0, "mtime lo after reset");
        expect_read(MTIME_HI_A, '0, "mtime hi after reset");
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            expect_read(cmp_addr(h, 0), '1, "mtimecmp lo after reset");
            expect_read(cmp_addr(h, 1), '1, "mtimecmp hi after reset");
        end
        end_test("reset_state");
    endtask

    task automatic timer_compare();
        clint_time_pkg::mtime_t t;
        clint_time_pkg::mtime_t delta;
        // High word nonzero so below and above never wrap
        t[63:32] = rand_bits(30) | 32'h1;
        t[31:0]  = rand_bits(32);
        set_mtime(t);
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            delta = clint_time_pkg::mtime_t'(rand_bits(8)) + 1;
            case (h % 3)
                0:       set_cmp(h, t - delta);
                1:       set_cmp(h, t);
                default: set_cmp(h, t + delta);
            endcase
        end
        @(negedge clk_i);
        check_harts(timer_irq_o, irq_model(), "timer_irq against compare rule");
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            expect_read(cmp_addr(h, 0), cmp_m[h][31:0], "mtimecmp lo read-back");
            expect_read(cmp_addr(h, 1), cmp_m[h][63:32], "mtimecmp hi read-back");
        end
        expect_read(MTIME_LO_A, t[31:0], "mtime lo read-back");
        expect_read(MTIME_HI_A, t[63:32], "mtime hi read-back");
        end_test("timer_compare");
    endtask

    task automatic rtc_counting();
        clint_time_pkg::mtime_t t0;
        int                     pulses;
        pulses = 3 + int'(rand_bits(2));
        t0     = {32'h1, rand_bits(32) & 32'h0000_FFFF};
        set_mtime(t0);
        set_cmp(1, t0 + 2);
        @(negedge clk_i);
        check_harts(timer_irq_o, irq_model(), "timer_irq before rtc pulses");
        for (int k = 0; k < pulses; k++) begin
            pulse_rtc();
            mtime_m = mtime_m + 1;
            wait_mtime_lo(mtime_m[31:0]);
            @(negedge clk_i);
            check_harts(timer_irq_o, irq_model(), "timer_irq while counting");
        end
        expect_read(MTIME_HI_A, mtime_m[63:32], "mtime hi after counting");
        end_test("rtc_counting");
    endtask

    task automatic direct_msip();
        clint_bus_pkg::data_t b;
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            b         = rand_bits(1);
            msip_m[h] = b[0];
            bus_write(msip_addr(h), b);
        end
        @(negedge clk_i);
        check_harts(ipi_o, msip_m, "ipi after direct writes");
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            expect_read(msip_addr(h), clint_bus_pkg::data_t'(msip_m[h]), "msip read-back");
        end
        end_test("direct_msip");
    endtask

    task automatic bcast_clear();
        clint_bus_pkg::data_t v;
        int                   n_set;
        int                   h_clr;
        // Hart 0 held set so any disturbance shows
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            bus_write(msip_addr(h), clint_bus_pkg::data_t'(h == 0));
        end
        msip_m = clint_time_pkg::hart_vec_t'(1);
        v      = rand_bits(2);
        bus_write(BCAST_A, v);
        for (int h = 1; h < `CLINT_NUM_HARTS; h++) begin
            if (h <= v + 1) begin
                msip_m[h] = 1'b1;
            end
        end
        @(negedge clk_i);
        check_harts(ipi_o, msip_m, "ipi after broadcast");
        // Clear one of the harts the broadcast just set
        n_set = (v + 1 < `CLINT_NUM_HARTS - 1) ? int'(v) + 1 : `CLINT_NUM_HARTS - 1;
        h_clr = 1 + int'(rand_bits(8)) % n_set;
        bus_write(CLR_A, clint_bus_pkg::data_t'(h_clr));
        msip_m[h_clr] = 1'b0;
        @(negedge clk_i);
        check_harts(ipi_o, msip_m, "ipi after clear");
        end_test("bcast_clear");
    endtask

    task automatic unmapped_access();
        bus_write(HOLE_A, rand_bits(32));
        bus_write(msip_addr(`CLINT_NUM_HARTS), 32'h1);
        bus_write(cmp_addr(0, 0) + 16'd2, rand_bits(32));
        @(negedge clk_i);
        check_harts(ipi_o, msip_m, "ipi after unmapped writes");
        check_harts(timer_irq_o, irq_model(), "timer_irq after unmapped writes");
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            expect_read(msip_addr(h), clint_bus_pkg::data_t'(msip_m[h]), "msip unchanged");
            expect_read(cmp_addr(h, 0), cmp_m[h][31:0], "mtimecmp lo unchanged");
            expect_read(cmp_addr(h, 1), cmp_m[h][63:32], "mtimecmp hi unchanged");
        end
        expect_read(MTIME_LO_A, mtime_m[31:0], "mtime lo unchanged");
        expect_read(MTIME_HI_A, mtime_m[63:32], "mtime hi unchanged");
        expect_read(HOLE_A, '0, "unmapped read");
        expect_read(BCAST_A, '0, "broadcast register read");
        end_test("unmapped");
    endtask

    initial begin
        rst_n_i       = 1'b0;
        req_i         = 1'b0;
        we_i          = 1'b0;
        addr_i        = '0;
        wdata_i       = '0;
        rtc_i         = 1'b0;
        lfsr          = 16'd17;
        errors        = 0;
        errors_before = 0;
        passed        = 0;
        failed        = 0;
        mtime_m       = '0;
        msip_m        = '0;
        for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
            cmp_m[h] = '1;
        end
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        reset_state();
        timer_compare();
        rtc_counting();
        direct_msip();
        bcast_clear();
        unmapped_access();

        $display("tests passed: %0d  failed: %0d  errors: %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: clint.f
+incdir+src
src/clint_bus_pkg.sv
src/clint_time_pkg.sv
src/clint_rtc_tick.sv
src/clint_reg_front.sv
src/clint_hart_slot.sv
src/clint_read_mux.sv
src/clint.sv
verif/tb_clint.sv

// File: run.sh
#!/bin/sh
set -e

# Build the testbench with Verilator and run it
verilator --binary --assert -Wno-fatal -f clint.f --top-module tb_clint \
    --Mdir obj_dir -o sim_clint
./obj_dir/sim_clint | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
